// File: ifetch_defines.svh
`ifndef IFETCH_DEFINES_SVH
`define IFETCH_DEFINES_SVH

//////////////////////
// fetch start
//////////////////////

`define IFETCH_RESET_PC 32'h3000_0000

//////////////////////
// cacheable window
//////////////////////

// sdram range, limit is exclusive
`define IFETCH_CACHE_BASE 32'ha000_0000
`define IFETCH_CACHE_LIMIT 32'ha200_0000

//////////////////////
// cache geometry
//////////////////////

`define IFETCH_LINE_WORDS 8 // 32 byte line
`define IFETCH_SETS 16

`endif

// File: ifetch_pkg.sv
`include "ifetch_defines.svh"

package ifetch_pkg;

	localparam int offset_bits = $clog2(`IFETCH_LINE_WORDS * 4);
	localparam int index_bits = $clog2(`IFETCH_SETS);
	localparam int tag_bits = 32 - index_bits - offset_bits;
	localparam int word_bits = $clog2(`IFETCH_LINE_WORDS);

	localparam logic [1:0] burst_fixed = 2'b00;
	localparam logic [1:0] burst_incr = 2'b01;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
		logic        fault; // non-okay read response
	} fetch_pkt_t;

	typedef logic [index_bits-1:0] line_index_t;
	typedef logic [tag_bits-1:0] line_tag_t;
	typedef logic [word_bits-1:0] word_sel_t;

	function automatic line_index_t addr_index(input logic [31:0] addr);
		return addr[offset_bits +: index_bits];
	endfunction

	function automatic line_tag_t addr_tag(input logic [31:0] addr);
		return addr[31 -: tag_bits];
	endfunction

	function automatic word_sel_t addr_word(input logic [31:0] addr);
		return addr[2 +: word_bits];
	endfunction

endpackage

// File: fetch_bus_if.sv
//////////////////////
// ctrl <-> icache, reader fills
//////////////////////

interface cache_lookup_if;
	import ifetch_pkg::*;

	logic        lookup_valid;
	logic [31:0] lookup_addr;
	logic        hit; // registered, one cycle after lookup
	logic [31:0] rdata;

	logic        fill_valid; // one word per accepted beat
	logic [31:0] fill_addr;
	logic [31:0] fill_data;
	logic        fill_last;
	axi_resp_e   fill_resp;

	modport ctrl (output lookup_valid, lookup_addr, input hit, rdata);
	modport cache (
		input  lookup_valid, lookup_addr,
		input  fill_valid, fill_addr, fill_data, fill_last, fill_resp,
		output hit, rdata
	);
	modport filler (output fill_valid, fill_addr, fill_data, fill_last, fill_resp);
endinterface

//////////////////////
// ctrl <-> refill reader
//////////////////////

interface refill_if;
	import ifetch_pkg::*;

	logic        req_valid; // taken when busy is low
	logic [31:0] req_addr;
	logic        req_burst;
	logic        busy;
	logic        beat_valid;
	logic [31:0] beat_data;
	axi_resp_e   beat_resp;
	logic        done; // beat with rlast

	modport ctrl (
		output req_valid, req_addr, req_burst,
		input  busy, beat_valid, beat_data, beat_resp, done
	);
	modport reader (
		input  req_valid, req_addr, req_burst,
		output busy, beat_valid, beat_data, beat_resp, done
	);
endinterface

// File: ifetch_ctrl.sv
`include "ifetch_defines.svh"

module ifetch_ctrl (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   redirect_valid,
	input  logic [31:0]            redirect_pc,
	output logic                   inst_valid,
	input  logic                   inst_ready,
	output ifetch_pkg::fetch_pkt_t pkt,
	cache_lookup_if.ctrl           lookup,
	refill_if.ctrl                 refill
);
	import ifetch_pkg::*;

	typedef enum logic [2:0] {
		st_lookup,
		st_wait_hit,
		st_refill,
		st_drain,
		st_hold
	} state_e;

	state_e      state;
	logic [31:0] pc;
	logic        cacheable;
	logic        req_taken;
	logic        discard; // redirect seen during this refill
	word_sel_t   beat_cnt;
	logic        beat_match;
	logic        take_hit;
	logic        take_beat;
	logic        xfer;

	//////////////////////
	// decode
	//////////////////////

	assign cacheable = (pc >= `IFETCH_CACHE_BASE) && (pc < `IFETCH_CACHE_LIMIT);
	assign xfer = inst_valid && inst_ready;

	assign lookup.lookup_valid = (state == st_lookup);
	assign lookup.lookup_addr = pc;

	// single cycle request, reader is idle here
	assign refill.req_valid = (state == st_refill) && !req_taken && !refill.busy;
	assign refill.req_addr = pc;
	assign refill.req_burst = cacheable;

	// uncached reads return only our word
	assign beat_match = !cacheable || (beat_cnt == addr_word(pc));

	assign take_hit = (state == st_wait_hit) && cacheable && lookup.hit && !redirect_valid;
	assign take_beat = (state == st_refill) && refill.beat_valid && beat_match
		&& !discard && !redirect_valid;

	//////////////////////
	// pc and fsm
	//////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_lookup;
			pc <= `IFETCH_RESET_PC;
			inst_valid <= 1'b0;
			req_taken <= 1'b0;
			discard <= 1'b0;
			beat_cnt <= '0;
		end else begin
			if (redirect_valid) pc <= redirect_pc;
			else if (xfer) pc <= pc + 32'd4;

			// held packet is dropped at once on redirect
			if (redirect_valid) inst_valid <= 1'b0;
			else if (take_hit || take_beat) inst_valid <= 1'b1;
			else if (xfer) inst_valid <= 1'b0;

			if (refill.req_valid) req_taken <= 1'b1;
			if (refill.beat_valid) beat_cnt <= beat_cnt + 1'b1;

			case (state)
				st_lookup: begin
					if (!redirect_valid) state <= st_wait_hit; // relook at new pc
				end
				st_wait_hit: begin
					if (redirect_valid) begin
						state <= st_lookup;
					end else if (take_hit) begin
						state <= st_hold;
					end else begin
						state <= st_refill;
						req_taken <= 1'b0;
						discard <= 1'b0;
						beat_cnt <= '0;
					end
				end
				st_refill: begin
					if (redirect_valid) discard <= 1'b1;
					// refill always runs to rlast
					if (refill.done) state <= take_beat ? st_hold : st_lookup;
					else if (take_beat) state <= st_drain;
				end
				st_drain: begin
					if (refill.done) state <= st_hold; // rest of line is in
				end
				st_hold: begin
					if (!inst_valid || xfer || redirect_valid) state <= st_lookup;
				end
				default: state <= st_lookup;
			endcase
		end
	end

	//////////////////////
	// packet to decode
	//////////////////////

	always_ff @(posedge clock) begin
		if (take_hit) begin
			pkt.pc <= pc;
			pkt.inst <= lookup.rdata;
			pkt.fault <= 1'b0;
		end else if (take_beat) begin
			pkt.pc <= pc;
			pkt.inst <= refill.beat_data;
			pkt.fault <= (refill.beat_resp != OKAY);
		end
	end

endmodule

// File: icache_array.sv
`include "ifetch_defines.svh"

module icache_array (
	input logic           clock,
	input logic           reset,
	cache_lookup_if.cache lookup,
	cache_lookup_if.cache fill
);
	import ifetch_pkg::*;

	logic [31:0] data_mem [`IFETCH_SETS][`IFETCH_LINE_WORDS];
	line_tag_t   tag_mem [`IFETCH_SETS];
	logic [`IFETCH_SETS-1:0] line_valid;

	line_index_t rd_index;
	line_tag_t   rd_tag;
	word_sel_t   rd_word;
	line_index_t fill_index;
	word_sel_t   fill_word;
	logic        fill_beat_ok;
	logic        fill_ok; // every beat of current line okay so far

	assign rd_index = addr_index(lookup.lookup_addr);
	assign rd_tag = addr_tag(lookup.lookup_addr);
	assign rd_word = addr_word(lookup.lookup_addr);

	assign fill_index = addr_index(fill.fill_addr);
	assign fill_word = addr_word(fill.fill_addr);
	assign fill_beat_ok = (fill.fill_resp == OKAY);

	//////////////////////
	// lookup
	//////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			lookup.hit <= 1'b0;
		end else if (lookup.lookup_valid) begin
			lookup.hit <= line_valid[rd_index] && (tag_mem[rd_index] == rd_tag);
		end
	end

	always_ff @(posedge clock) begin
		if (lookup.lookup_valid) lookup.rdata <= data_mem[rd_index][rd_word];
	end

	//////////////////////
	// line fill
	//////////////////////

	always_ff @(posedge clock) begin
		if (fill.fill_valid) begin
			data_mem[fill_index][fill_word] <= fill.fill_data;
			tag_mem[fill_index] <= addr_tag(fill.fill_addr);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
			fill_ok <= 1'b1;
		end else if (fill.fill_valid) begin
			if (fill.fill_last) begin
				// a faulted line stays invalid and is refetched later
				line_valid[fill_index] <= fill_ok && fill_beat_ok;
				fill_ok <= 1'b1;
			end else begin
				line_valid[fill_index] <= 1'b0; // old line is being overwritten
				fill_ok <= fill_ok && fill_beat_ok;
			end
		end
	end

endmodule

// File: refill_reader.sv
`include "ifetch_defines.svh"

module refill_reader (
	input  logic                  clock,
	input  logic                  reset,
	refill_if.reader              refill,
	cache_lookup_if.filler        fill,
	output logic [31:0]           araddr,
	output logic                  arvalid,
	output logic [3:0]            arlen,
	output logic [1:0]            arburst,
	input  logic                  arready,
	input  logic                  rvalid,
	input  logic                  rlast,
	input  logic [31:0]           rdata,
	input  ifetch_pkg::axi_resp_e rresp,
	output logic                  rready
);
	import ifetch_pkg::*;

	logic      busy;
	logic      take;
	logic      beat;
	word_sel_t beat_cnt;

	assign rready = 1'b1;
	assign take = refill.req_valid && !busy;
	assign beat = busy && rvalid && rready;

	assign refill.busy = busy;
	assign refill.beat_valid = beat;
	assign refill.beat_data = rdata;
	assign refill.beat_resp = rresp;
	assign refill.done = beat && rlast;

	// uncached beats never touch the cache
	assign fill.fill_valid = beat && (arburst == burst_incr);
	assign fill.fill_addr = {araddr[31:offset_bits], beat_cnt, 2'b00};
	assign fill.fill_data = rdata;
	assign fill.fill_last = rlast;
	assign fill.fill_resp = rresp;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			arvalid <= 1'b0;
			beat_cnt <= '0;
		end else begin
			if (take) begin
				busy <= 1'b1;
				arvalid <= 1'b1; // up the cycle after the request
				beat_cnt <= '0;
			end else if (arvalid && arready) begin
				arvalid <= 1'b0;
			end
			if (beat) begin
				beat_cnt <= beat_cnt + 1'b1;
				if (rlast) busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			if (refill.req_burst) begin
				araddr <= {refill.req_addr[31:offset_bits], {offset_bits{1'b0}}}; // line aligned
				arlen <= 4'(`IFETCH_LINE_WORDS - 1);
				arburst <= burst_incr;
			end else begin
				araddr <= refill.req_addr;
				arlen <= 4'd0;
				arburst <= burst_fixed;
			end
		end
	end

endmodule

// File: ifetch_top.sv
module ifetch_top (
	input  logic                  clock,
	input  logic                  reset,

	output logic [31:0]           araddr,
	output logic                  arvalid,
	output logic [3:0]            arlen,
	output logic [1:0]            arburst,
	output logic                  rready,
	input  logic                  arready,
	input  logic [31:0]           rdata,
	input  ifetch_pkg::axi_resp_e rresp,
	input  logic                  rlast,
	input  logic                  rvalid,

	input  logic                  redirect_valid,
	input  logic [31:0]           redirect_pc,

	output logic                  inst_valid,
	output logic [31:0]           inst,
	output logic [31:0]           inst_pc,
	output logic                  inst_fault,
	input  logic                  inst_ready
);
	import ifetch_pkg::*;

	fetch_pkt_t pkt;

	cache_lookup_if u_lookup_if ();
	refill_if u_refill_if ();

	ifetch_ctrl u_ctrl (
		.clock          (clock),
		.reset          (reset),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.inst_valid     (inst_valid),
		.inst_ready     (inst_ready),
		.pkt            (pkt),
		.lookup         (u_lookup_if),
		.refill         (u_refill_if)
	);

	icache_array u_icache (
		.clock  (clock),
		.reset  (reset),
		.lookup (u_lookup_if),
		.fill   (u_lookup_if) // fill side of the same link
	);

	refill_reader u_reader (
		.clock   (clock),
		.reset   (reset),
		.refill  (u_refill_if),
		.fill    (u_lookup_if),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arlen   (arlen),
		.arburst (arburst),
		.arready (arready),
		.rvalid  (rvalid),
		.rlast   (rlast),
		.rdata   (rdata),
		.rresp   (rresp),
		.rready  (rready)
	);

	assign inst = pkt.inst;
	assign inst_pc = pkt.pc;
	assign inst_fault = pkt.fault;

endmodule

// File: ifetch_properties.sv
module ifetch_properties (
	input logic        clock,
	input logic        reset,
	input logic        arvalid,
	input logic        arready,
	input logic [3:0]  arlen,
	input logic [1:0]  arburst,
	input logic        redirect_valid,
	input logic        inst_valid,
	input logic        inst_ready,
	input logic [31:0] inst,
	input logic [31:0] inst_pc,
	input logic        inst_fault
);
	import ifetch_pkg::*;

	//////////////////////
	// read address channel
	//////////////////////

	property ar_held;
		@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid;
	endproperty

	property burst_len_match;
		@(posedge clock) disable iff (reset)
		arvalid |-> ((arlen == 4'd7) == (arburst == burst_incr));
	endproperty

	//////////////////////
	// decode handshake
	//////////////////////

	// a redirect may drop the held packet
	property pkt_stable;
		@(posedge clock) disable iff (reset)
		inst_valid && !inst_ready && !redirect_valid
			|=> inst_valid && $stable(inst) && $stable(inst_pc) && $stable(inst_fault);
	endproperty

	a_ar_held: assert property (ar_held) else $error("arvalid dropped before arready");
	a_burst_len: assert property (burst_len_match) else $error("arlen does not fit arburst");
	a_pkt_stable: assert property (pkt_stable) else $error("packet changed while stalled");

endmodule

bind ifetch_top ifetch_properties u_properties (
	.clock          (clock),
	.reset          (reset),
	.arvalid        (arvalid),
	.arready        (arready),
	.arlen          (arlen),
	.arburst        (arburst),
	.redirect_valid (redirect_valid),
	.inst_valid     (inst_valid),
	.inst_ready     (inst_ready),
	.inst           (inst),
	.inst_pc        (inst_pc),
	.inst_fault     (inst_fault)
);

// File: tb_ifetch.sv
`include "ifetch_defines.svh"

module tb_ifetch;
	import ifetch_pkg::*;

	localparam int off_w = $clog2(`IFETCH_LINE_WORDS * 4);
	localparam int idx_w = $clog2(`IFETCH_SETS);

	logic clock = 1'b0;
	logic reset;
	logic [31:0] araddr;
	logic arvalid;
	logic [3:0] arlen;
	logic [1:0] arburst;
	logic rready;
	logic arready;
	logic [31:0] rdata;
	axi_resp_e rresp;
	logic rlast;
	logic rvalid;
	logic redirect_valid;
	logic [31:0] redirect_pc;
	logic inst_valid;
	logic [31:0] inst;
	logic [31:0] inst_pc;
	logic inst_fault;
	logic inst_ready;

	logic [31:0] vec [0:127];
	logic [31:0] mem_img [logic [31:0]];
	bit fault_set [logic [31:0]];
	logic [31:0] ev_after [0:15];
	logic [31:0] ev_delay [0:15];
	logic [31:0] ev_target [0:15];
	int ev_count;
	int exp_total;
	int cycle_limit;
	int cycles;
	bit run_done;
	int pkt_errors;
	int resp_errors;
	int bus_errors;

	// expected stream
	int pkt_count;
	int next_ev;
	int redir_wait;
	logic [31:0] redir_target;
	logic [31:0] exp_pc;

	// memory model state
	bit rd_active;
	bit rd_burst;
	bit rd_line_fault;
	logic [31:0] rd_addr;
	int rd_len;
	int rd_idx;
	int ar_wait;
	int beat_gap;
	int burst_count;
	bit line_ok [`IFETCH_SETS];
	logic [31:0] line_tag [`IFETCH_SETS];

	ifetch_top u_ifetch_top (
		.clock          (clock),
		.reset          (reset),
		.araddr         (araddr),
		.arvalid        (arvalid),
		.arlen          (arlen),
		.arburst        (arburst),
		.rready         (rready),
		.arready        (arready),
		.rdata          (rdata),
		.rresp          (rresp),
		.rlast          (rlast),
		.rvalid         (rvalid),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.inst_valid     (inst_valid),
		.inst           (inst),
		.inst_pc        (inst_pc),
		.inst_fault     (inst_fault),
		.inst_ready     (inst_ready)
	);

	always #2 clock = ~clock;

	//////////////////////
	// helpers
	//////////////////////

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		if (mem_img.exists(addr)) return mem_img[addr];
		return {addr[15:0], addr[31:16]} ^ 32'h6b3d_90e1; // unlisted words
	endfunction

	function automatic bit in_window(input logic [31:0] addr);
		return (addr >= `IFETCH_CACHE_BASE) && (addr < `IFETCH_CACHE_LIMIT);
	endfunction

	task check_pkt(input fetch_pkt_t exp, input fetch_pkt_t act);
		if (act.pc !== exp.pc) begin
			$display("[ERROR] inst_pc expected %h got %h", exp.pc, act.pc);
			pkt_errors++;
		end
		if (act.inst !== exp.inst) begin
			$display("[ERROR] inst expected %h got %h", exp.inst, act.inst);
			pkt_errors++;
		end
	endtask

	task check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %h got %h", name, exp, act);
			resp_errors++;
		end
	endtask

	task check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s expected %h got %h", name, exp, act);
			bus_errors++;
		end
	endtask

	task accept_ar();
		logic [idx_w-1:0] idx;
		rd_addr = araddr;
		rd_len = int'(arlen);
		rd_idx = 0;
		rd_active = 1'b1;
		rd_burst = in_window(araddr);
		idx = araddr[off_w +: idx_w];
		if (rd_burst) begin
			check_value("arburst", 32'(burst_incr), 32'(arburst));
			check_value("arlen", 32'd7, 32'(arlen));
			check_value("araddr offset", 32'd0, 32'(araddr[off_w-1:0]));
			if (line_ok[idx] && line_tag[idx] == (araddr >> (off_w + idx_w))) begin
				$display("burst issued for a line already held in the cache at %h", araddr);
				bus_errors++;
			end
			line_ok[idx] = 1'b0; // being overwritten
			rd_line_fault = 1'b0;
			for (int i = 0; i < `IFETCH_LINE_WORDS; i++)
				if (fault_set.exists(araddr + 32'(4 * i))) rd_line_fault = 1'b1;
			burst_count++;
		end else begin
			check_value("arburst", 32'(burst_fixed), 32'(arburst));
			check_value("arlen", 32'd0, 32'(arlen));
		end
	endtask

	//////////////////////
	// axi read memory
	//////////////////////

	always @(posedge clock) begin
		logic [31:0] baddr;
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			rdata <= '0;
			rresp <= OKAY;
			rd_active = 1'b0;
			ar_wait = $urandom_range(3);
			beat_gap = 0;
		end else begin
			check_value("rready", 32'd1, 32'(rready));
			if (rvalid) begin // rready is tied high
				if (rlast) begin
					rd_active = 1'b0;
					if (rd_burst) begin
						line_ok[rd_addr[off_w +: idx_w]] = !rd_line_fault;
						line_tag[rd_addr[off_w +: idx_w]] = rd_addr >> (off_w + idx_w);
					end
				end else begin
					rd_idx++;
				end
			end
			rvalid <= 1'b0;
			if (arvalid && arready) begin
				arready <= 1'b0;
				accept_ar();
				beat_gap = $urandom_range(2);
			end else if (arvalid && !rd_active) begin
				if (ar_wait == 0) begin
					arready <= 1'b1;
					ar_wait = $urandom_range(3);
				end else begin
					ar_wait--;
				end
			end
			if (rd_active) begin
				if (beat_gap == 0) begin
					baddr = rd_burst ? rd_addr + 32'(4 * rd_idx) : rd_addr;
					rdata <= mem_word(baddr);
					rresp <= fault_set.exists(baddr) ? SLVERR : OKAY;
					rlast <= (rd_idx == rd_len);
					rvalid <= 1'b1;
					beat_gap = $urandom_range(2);
				end else begin
					beat_gap--;
				end
			end
		end
	end

	//////////////////////
	// decode side
	//////////////////////

	always @(posedge clock) begin
		fetch_pkt_t exp;
		fetch_pkt_t act;
		if (reset) begin
			inst_ready <= 1'b0;
			redirect_valid <= 1'b0;
			redirect_pc <= '0;
		end else begin
			redirect_valid <= 1'b0;
			if (redir_wait > 0) begin
				redir_wait--;
				if (redir_wait == 0) begin
					redirect_valid <= 1'b1;
					redirect_pc <= redir_target;
				end
				inst_ready <= 1'b0; // hold until the redirect lands
			end else begin
				inst_ready <= ($urandom_range(3) != 0);
			end
			if (inst_valid && inst_ready && pkt_count < exp_total) begin
				exp.pc = exp_pc;
				exp.inst = mem_word(exp_pc);
				exp.fault = fault_set.exists(exp_pc);
				act.pc = inst_pc;
				act.inst = inst;
				act.fault = inst_fault;
				check_pkt(exp, act);
				check_resp("inst_fault", exp.fault ? SLVERR : OKAY, act.fault ? SLVERR : OKAY);
				pkt_count++;
				if (next_ev < ev_count && ev_after[next_ev] == 32'(pkt_count)) begin
					exp_pc = ev_target[next_ev];
					redir_target = ev_target[next_ev];
					redir_wait = int'(ev_delay[next_ev]);
					inst_ready <= 1'b0;
					next_ev++;
				end else begin
					exp_pc = exp_pc + 32'd4;
				end
			end
		end
	end

	//////////////////////
	// run
	//////////////////////

	initial begin : watchdog
		@(posedge clock);
		while (!run_done && cycles < cycle_limit) begin
			@(posedge clock);
			cycles++;
		end
		if (!run_done) begin
			$display("fetch stream stalled after %0d of %0d packets", pkt_count, exp_total);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		int p;
		void'($urandom(32'h9c22));
		$readmemh("ifetch_vectors.txt", vec);
		ev_count = int'(vec[2]);
		exp_total = int'(vec[3]);
		cycle_limit = 200 * exp_total;
		p = 4;
		for (int i = 0; i < int'(vec[0]); i++) begin
			mem_img[vec[p]] = vec[p + 1];
			p += 2;
		end
		for (int i = 0; i < int'(vec[1]); i++) begin
			fault_set[vec[p]] = 1'b1;
			p++;
		end
		for (int i = 0; i < ev_count; i++) begin
			ev_after[i] = vec[p];
			ev_delay[i] = vec[p + 1];
			ev_target[i] = vec[p + 2];
			p += 3;
		end
		exp_pc = `IFETCH_RESET_PC;
		reset <= 1'b1;
		inst_ready <= 1'b0;
		redirect_valid <= 1'b0;
		redirect_pc <= '0;
		arready <= 1'b0;
		rvalid <= 1'b0;
		rlast <= 1'b0;
		rdata <= '0;
		rresp <= OKAY;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		wait (pkt_count == exp_total);
		repeat (10) @(posedge clock);
		run_done = 1'b1;
		$display("errors: packet %0d, response %0d, bus %0d (%0d bursts)",
			pkt_errors, resp_errors, bus_errors, burst_count);
		if (pkt_errors + resp_errors + bus_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: ifetch_vectors.txt
// header: memory entries, fault addresses, redirect events, expected packets
// then memory image (address data), fault addresses, redirects (after_n delay target)
00000008
00000002
00000005
00000030
// memory image
30000000 00000013
30000004 00100093
3000000c 00208113
a0000000 0000006f
a0000004 00c58533
a000001c fe010113
a0000024 deadbeef
a1000000 00008067
// addresses that answer slverr
30000008
a0000024
// redirects, after_n packets and cycles of delay
00000004 00000004 a0000000
00000014 00000001 a0000000
00000018 00000008 a0000010
00000024 00000004 a1000000
0000002c 00000001 a0000000

// File: ifetch_top.f
+incdir+.
ifetch_pkg.sv
fetch_bus_if.sv
ifetch_ctrl.sv
icache_array.sv
refill_reader.sv
ifetch_top.sv
ifetch_properties.sv
tb_ifetch.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_ifetch -f ifetch_top.f

output=$(./obj_dir/Vtb_ifetch 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1
